//--- source/renderer_pkg.sv
/* Shared widths, register and scan structs, and the render state enum
   for the tile-layer scanline renderer */
`default_nettype none

package renderer_pkg;

  // Register file fields
  localparam int REG_DATA_WIDTH = 16;

  // Tilemap word and address, address is {layer, map row, map column}
  localparam int MAP_ADDR_WIDTH = 11;
  localparam int MAP_DATA_WIDTH = 16;
  localparam int TILE_FLIP_X_BIT = 15;
  localparam int TILE_FLIP_Y_BIT = 14;
  localparam int TILE_FLIP_XY_BIT = 13;

  // Tiles are 16 by 16 texels
  localparam int TILE_SIZE_LOG2 = 4;

  // VRAM holds two 8-bit texels per word, even texel in the low byte
  localparam int VRAM_ADDR_WIDTH = 16;
  localparam int VRAM_DATA_WIDTH = 16;
  localparam int TEXEL_WIDTH = 8;

  // Palette address is {bank, texel}, data is {blue, green, red}
  localparam int PAL_INDEX_WIDTH = 2;
  localparam int PAL_ADDR_WIDTH = 10;
  localparam int PAL_DATA_WIDTH = 24;
  localparam int RGB_WIDTH = 18;

  // Image coordinate widths, enough for up to 512 by 256 images
  localparam int IMAGE_X_WIDTH = 9;
  localparam int IMAGE_Y_WIDTH = 8;

  // Cycles from render_x to the line buffer write
  localparam int RENDER_DELAY = 4;

  typedef struct packed {
    logic enabled;
    logic flip_enable;
    logic nop_enable;
    logic transp_enable;
    logic [PAL_INDEX_WIDTH-1:0] palette;
    logic [REG_DATA_WIDTH-1:0] nop_value;
    logic [REG_DATA_WIDTH-1:0] color_key;
    logic [REG_DATA_WIDTH-1:0] data_offset;
    logic [REG_DATA_WIDTH-1:0] offset_x;
    logic [REG_DATA_WIDTH-1:0] offset_y;
  } tile_layer_regs_t;

  typedef struct packed {
    logic [REG_DATA_WIDTH-1:0] scroll_x;
    logic [REG_DATA_WIDTH-1:0] scroll_y;
  } scroll_regs_t;

  typedef struct packed {
    logic visible;
    logic [IMAGE_X_WIDTH-1:0] image_x;
    logic row_odd;
    logic col_odd;
    logic buf_half;
  } scan_pos_t;

  typedef enum logic [1:0] {
    idle,
    decide,
    draw_layer
  } render_state_t;

endpackage

`default_nettype wire

//--- source/scan_timing.sv
/* Raster counters, sync outputs, render start strobe and scanout position */
`timescale 1ns/1ps
`default_nettype none

module scan_timing #(
  parameter int IMAGE_WIDTH = 320,
  parameter int IMAGE_HEIGHT = 240,
  parameter int H_TOTAL = 800,
  parameter int H_SYNC_START = 656,
  parameter int H_SYNC_END = 752,
  parameter int V_TOTAL = 525,
  parameter int V_SYNC_START = 490,
  parameter int V_SYNC_END = 492
) (
  input  logic clk,
  input  logic reset,
  output logic render_start,
  output logic [renderer_pkg::IMAGE_Y_WIDTH-1:0] render_row,
  output logic render_half,
  output renderer_pkg::scan_pos_t scan_pos,
  output logic h_sync,
  output logic v_sync
);
  import renderer_pkg::*;

  localparam int H_WIDTH = $clog2(H_TOTAL);
  localparam int V_WIDTH = $clog2(V_TOTAL);

  logic [H_WIDTH-1:0] h_count;
  logic [V_WIDTH-1:0] v_count;
  logic line_end;
  logic last_pair;
  logic render_pair;

  assign line_end = h_count == H_WIDTH'(H_TOTAL - 1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      h_count <= '0;
      v_count <= '0;
      h_sync <= 1'b1;
      v_sync <= 1'b1;
    end else begin
      if (line_end) begin
        h_count <= '0;
        v_count <= (v_count == V_WIDTH'(V_TOTAL - 1)) ? '0 : v_count + 1'b1;
      end else begin
        h_count <= h_count + 1'b1;
      end
      // Syncs are active low
      h_sync <= !(h_count >= H_SYNC_START && h_count < H_SYNC_END);
      v_sync <= !(v_count >= V_SYNC_START && v_count < V_SYNC_END);
    end
  end

  // Last blanking pair prepares row 0 for the next frame
  assign last_pair = v_count >= V_WIDTH'(V_TOTAL - 2);
  // No render in the last visible pair, nothing follows it on screen
  assign render_pair = (v_count < V_WIDTH'(2 * IMAGE_HEIGHT - 2)) || last_pair;
  assign render_start = (h_count == '0) && !v_count[0] && render_pair;

  // Row shown by the next line pair
  assign render_row = last_pair ? '0 : IMAGE_Y_WIDTH'(v_count >> 1) + 1'b1;
  assign render_half = render_row[0];

  // Each image pixel covers two columns and two lines
  assign scan_pos.visible = (h_count < H_WIDTH'(2 * IMAGE_WIDTH)) &&
                            (v_count < V_WIDTH'(2 * IMAGE_HEIGHT));
  assign scan_pos.image_x = IMAGE_X_WIDTH'(h_count >> 1);
  assign scan_pos.row_odd = v_count[0];
  assign scan_pos.col_odd = h_count[0];
  // Half holding the row on screen now
  assign scan_pos.buf_half = v_count[1];

endmodule

`default_nettype wire

//--- source/layer_sequencer.sv
/* Render FSM that walks the tile layers and steps render_x over one row */
`timescale 1ns/1ps
`default_nettype none

module layer_sequencer #(
  parameter int IMAGE_WIDTH = 320,
  parameter int NUM_LAYERS = 2
) (
  input  logic clk,
  input  logic reset,
  input  logic render_start,
  input  renderer_pkg::tile_layer_regs_t [NUM_LAYERS-1:0] layer_regs,
  output logic draw,
  output logic layer,
  output logic [renderer_pkg::IMAGE_X_WIDTH-1:0] render_x
);
  import renderer_pkg::*;

  // One extra count marks that every layer is done
  localparam int COUNT_WIDTH = $clog2(NUM_LAYERS + 1);

  render_state_t state;
  logic [COUNT_WIDTH-1:0] layer_count;
  logic row_end;

  assign row_end = render_x == IMAGE_X_WIDTH'(IMAGE_WIDTH - 1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= idle;
      layer_count <= '0;
      render_x <= '0;
    end else begin
      case (state)
        idle: begin
          // New row pair, start from the bottom layer
          if (render_start) begin
            state <= decide;
            layer_count <= '0;
          end
        end
        decide: begin
          if (layer_count == COUNT_WIDTH'(NUM_LAYERS)) begin
            state <= idle;
          end else if (layer_regs[layer].enabled) begin
            state <= draw_layer;
            render_x <= '0;
          end else begin
            // Disabled layer costs one cycle
            layer_count <= layer_count + 1'b1;
          end
        end
        draw_layer: begin
          if (row_end) begin
            state <= decide;
            layer_count <= layer_count + 1'b1;
          end else begin
            render_x <= render_x + 1'b1;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Tilemap holds one layer bit
  assign layer = layer_count[0];
  assign draw = state == draw_layer;

endmodule

`default_nettype wire

//--- source/tile_fetch.sv
/* Tile fetch pipeline from render_x through tilemap, VRAM and palette
   to the line buffer write */
`timescale 1ns/1ps
`default_nettype none

module tile_fetch #(
  parameter int IMAGE_WIDTH = 320,
  parameter int NUM_LAYERS = 2
) (
  input  logic clk,
  input  logic reset,
  input  logic draw,
  input  logic layer,
  input  logic [renderer_pkg::IMAGE_X_WIDTH-1:0] render_x,
  input  logic [renderer_pkg::IMAGE_Y_WIDTH-1:0] render_row,
  input  logic render_half,
  input  renderer_pkg::tile_layer_regs_t [NUM_LAYERS-1:0] layer_regs,
  input  renderer_pkg::scroll_regs_t scroll,
  output logic [renderer_pkg::MAP_ADDR_WIDTH-1:0] map_addr,
  input  logic [renderer_pkg::MAP_DATA_WIDTH-1:0] map_data,
  output logic [renderer_pkg::VRAM_ADDR_WIDTH-1:0] vram_addr,
  input  logic [renderer_pkg::VRAM_DATA_WIDTH-1:0] vram_data,
  output logic [renderer_pkg::PAL_ADDR_WIDTH-1:0] pal_addr,
  input  logic [renderer_pkg::PAL_DATA_WIDTH-1:0] pal_data,
  output logic wr_en,
  output logic [$clog2(2 * IMAGE_WIDTH)-1:0] wr_addr,
  output logic [renderer_pkg::PAL_DATA_WIDTH-1:0] wr_data
);
  import renderer_pkg::*;

  localparam int LB_ADDR_WIDTH = $clog2(2 * IMAGE_WIDTH);
  localparam int MAP_COORD_WIDTH = (MAP_ADDR_WIDTH - 1) / 2;
  localparam int TILE_WORD_WIDTH = MAP_DATA_WIDTH + 2 * TILE_SIZE_LOG2 - 1;

  logic [REG_DATA_WIDTH-1:0] world_x;
  logic [REG_DATA_WIDTH-1:0] world_y;
  logic [LB_ADDR_WIDTH-1:0] line_addr;
  logic [RENDER_DELAY-1:0] valid_pipe;
  logic [LB_ADDR_WIDTH-1:0] addr_pipe [RENDER_DELAY];
  tile_layer_regs_t s1_regs;
  tile_layer_regs_t s2_regs;
  logic [TILE_SIZE_LOG2-1:0] s1_tx;
  logic [TILE_SIZE_LOG2-1:0] s1_ty;
  logic flip_x;
  logic flip_y;
  logic flip_xy;
  logic [MAP_DATA_WIDTH-1:0] tile_value;
  logic [TILE_SIZE_LOG2-1:0] tex_x;
  logic [TILE_SIZE_LOG2-1:0] tex_y;
  logic [TILE_WORD_WIDTH-1:0] tile_word;
  logic s2_byte_sel;
  logic s2_nop;
  logic [TEXEL_WIDTH-1:0] texel;
  logic s3_keep;
  logic wr_keep;

  // Cycle 0
  // World position is image position plus scroll minus layer offset
  assign world_x = REG_DATA_WIDTH'(render_x) + scroll.scroll_x - layer_regs[layer].offset_x;
  assign world_y = REG_DATA_WIDTH'(render_row) + scroll.scroll_y - layer_regs[layer].offset_y;
  assign map_addr = {layer, world_y[TILE_SIZE_LOG2 +: MAP_COORD_WIDTH],
                     world_x[TILE_SIZE_LOG2 +: MAP_COORD_WIDTH]};
  assign line_addr = LB_ADDR_WIDTH'(render_x) +
                     (render_half ? LB_ADDR_WIDTH'(IMAGE_WIDTH) : '0);

  // Valid and write address ride alongside the data stages
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[RENDER_DELAY-2:0], draw};
    end
  end

  always_ff @(posedge clk) begin
    addr_pipe[0] <= line_addr;
    for (int i = 1; i < RENDER_DELAY; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
  end

  // Cycle 1 takes the map word
  // Flip bits count only with flip_enable
  always_comb begin
    flip_x = s1_regs.flip_enable & map_data[TILE_FLIP_X_BIT];
    flip_y = s1_regs.flip_enable & map_data[TILE_FLIP_Y_BIT];
    flip_xy = s1_regs.flip_enable & map_data[TILE_FLIP_XY_BIT];
    tile_value = map_data;
    if (s1_regs.flip_enable) begin
      tile_value[TILE_FLIP_X_BIT] = 1'b0;
      tile_value[TILE_FLIP_Y_BIT] = 1'b0;
      tile_value[TILE_FLIP_XY_BIT] = 1'b0;
    end
    // Diagonal swap first and then mirror each axis
    tex_x = flip_xy ? s1_ty : s1_tx;
    tex_y = flip_xy ? s1_tx : s1_ty;
    if (flip_x) begin
      tex_x = ~tex_x;
    end
    if (flip_y) begin
      tex_y = ~tex_y;
    end
    tile_word = {tile_value, tex_y, tex_x[TILE_SIZE_LOG2-1:1]};
  end

  // Cycle 2 picks the texel byte and prepends the palette bank
  assign texel = s2_byte_sel ? vram_data[2*TEXEL_WIDTH-1 -: TEXEL_WIDTH]
                             : vram_data[TEXEL_WIDTH-1:0];
  assign pal_addr = {s2_regs.palette, texel};

  always_ff @(posedge clk) begin
    s1_regs <= layer_regs[layer];
    s1_tx <= world_x[TILE_SIZE_LOG2-1:0];
    s1_ty <= world_y[TILE_SIZE_LOG2-1:0];
    // Data offset counts bytes but VRAM is word addressed
    vram_addr <= tile_word[VRAM_ADDR_WIDTH-1:0] +
                 {1'b0, s1_regs.data_offset[REG_DATA_WIDTH-1:1]};
    s2_regs <= s1_regs;
    s2_byte_sel <= tex_x[0];
    s2_nop <= s1_regs.nop_enable && (map_data == s1_regs.nop_value);
    s3_keep <= !s2_nop &&
               !(s2_regs.transp_enable && (REG_DATA_WIDTH'(texel) == s2_regs.color_key));
    // Cycle 3 brings the palette color
    wr_keep <= s3_keep;
    wr_data <= pal_data;
  end

  // Cycle 4 writes unless nop tile or color key
  assign wr_en = valid_pipe[RENDER_DELAY-1] & wr_keep;
  assign wr_addr = addr_pipe[RENDER_DELAY-1];

endmodule

`default_nettype wire

//--- source/line_buffer.sv
/* Double line buffer RAM with one write port and a read-then-clear port */
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
  parameter int IMAGE_WIDTH = 320
) (
  input  logic clk,
  input  logic wr_en,
  input  logic [$clog2(2 * IMAGE_WIDTH)-1:0] wr_addr,
  input  logic [renderer_pkg::PAL_DATA_WIDTH-1:0] wr_data,
  input  logic [$clog2(2 * IMAGE_WIDTH)-1:0] rd_addr,
  input  logic clear,
  output logic [renderer_pkg::PAL_DATA_WIDTH-1:0] rd_data
);
  import renderer_pkg::*;

  // Two halves of one image row each
  localparam int DEPTH = 2 * IMAGE_WIDTH;

  logic [PAL_DATA_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    // Registered read sees the old entry
    rd_data <= mem[rd_addr];
    // Last read of a pixel leaves it empty for the next row
    if (clear) begin
      mem[rd_addr] <= '0;
    end
    // Render side only touches the other half
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

//--- source/scanout.sv
/* Line buffer read addressing, clear control, color reduction and data enable */
`timescale 1ns/1ps
`default_nettype none

module scanout #(
  parameter int IMAGE_WIDTH = 320
) (
  input  logic clk,
  input  logic reset,
  input  renderer_pkg::scan_pos_t scan_pos,
  output logic [$clog2(2 * IMAGE_WIDTH)-1:0] rd_addr,
  output logic clear,
  input  logic [renderer_pkg::PAL_DATA_WIDTH-1:0] rd_data,
  output logic [renderer_pkg::RGB_WIDTH-1:0] rgb_out,
  output logic de
);
  import renderer_pkg::*;

  localparam int LB_ADDR_WIDTH = $clog2(2 * IMAGE_WIDTH);
  localparam int CHAN_WIDTH = RGB_WIDTH / 3;
  localparam int BYTE_WIDTH = PAL_DATA_WIDTH / 3;

  logic visible_d;

  // Read the half finished during the previous line pair
  assign rd_addr = LB_ADDR_WIDTH'(scan_pos.image_x) +
                   (scan_pos.buf_half ? LB_ADDR_WIDTH'(IMAGE_WIDTH) : '0);
  // Fourth read of a pixel, odd column of odd line
  assign clear = scan_pos.visible & scan_pos.row_odd & scan_pos.col_odd;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      visible_d <= 1'b0;
      de <= 1'b0;
      rgb_out <= '0;
    end else begin
      // Visibility follows the one-cycle RAM read
      visible_d <= scan_pos.visible;
      de <= visible_d;
      // Top bits of blue, green, red, black outside the active area
      rgb_out <= visible_d ? {rd_data[3*BYTE_WIDTH-1 -: CHAN_WIDTH],
                              rd_data[2*BYTE_WIDTH-1 -: CHAN_WIDTH],
                              rd_data[BYTE_WIDTH-1 -: CHAN_WIDTH]} : '0;
    end
  end

endmodule

`default_nettype wire

//--- source/renderer.sv
/* Top level of the tile-layer renderer, timing, sequencer, fetch pipeline,
   line buffer and scanout */
`timescale 1ns/1ps
`default_nettype none

module renderer #(
  parameter int IMAGE_WIDTH = 320,
  parameter int IMAGE_HEIGHT = 240,
  parameter int H_TOTAL = 800,
  parameter int H_SYNC_START = 656,
  parameter int H_SYNC_END = 752,
  parameter int V_TOTAL = 525,
  parameter int V_SYNC_START = 490,
  parameter int V_SYNC_END = 492,
  parameter int NUM_LAYERS = 2
) (
  input  logic clk,
  input  logic reset,
  input  renderer_pkg::tile_layer_regs_t [NUM_LAYERS-1:0] layer_regs,
  input  renderer_pkg::scroll_regs_t scroll,
  output logic [renderer_pkg::MAP_ADDR_WIDTH-1:0] map_addr,
  input  logic [renderer_pkg::MAP_DATA_WIDTH-1:0] map_data,
  output logic [renderer_pkg::VRAM_ADDR_WIDTH-1:0] vram_addr,
  input  logic [renderer_pkg::VRAM_DATA_WIDTH-1:0] vram_data,
  output logic [renderer_pkg::PAL_ADDR_WIDTH-1:0] pal_addr,
  input  logic [renderer_pkg::PAL_DATA_WIDTH-1:0] pal_data,
  output logic h_sync,
  output logic v_sync,
  output logic [renderer_pkg::RGB_WIDTH-1:0] rgb_out,
  output logic de
);
  import renderer_pkg::*;

  localparam int LB_ADDR_WIDTH = $clog2(2 * IMAGE_WIDTH);

  // Raster to render side
  logic render_start;
  logic [IMAGE_Y_WIDTH-1:0] render_row;
  logic render_half;
  scan_pos_t scan_pos;
  // Sequencer to fetch pipeline
  logic draw;
  logic layer;
  logic [IMAGE_X_WIDTH-1:0] render_x;
  // Line buffer ports
  logic wr_en;
  logic [LB_ADDR_WIDTH-1:0] wr_addr;
  logic [PAL_DATA_WIDTH-1:0] wr_data;
  logic [LB_ADDR_WIDTH-1:0] rd_addr;
  logic clear;
  logic [PAL_DATA_WIDTH-1:0] rd_data;

  scan_timing #(
    .IMAGE_WIDTH(IMAGE_WIDTH), .IMAGE_HEIGHT(IMAGE_HEIGHT),
    .H_TOTAL(H_TOTAL), .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
    .V_TOTAL(V_TOTAL), .V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END)
  ) u_scan_timing (
    .clk(clk), .reset(reset), .render_start(render_start),
    .render_row(render_row), .render_half(render_half),
    .scan_pos(scan_pos), .h_sync(h_sync), .v_sync(v_sync)
  );

  layer_sequencer #(.IMAGE_WIDTH(IMAGE_WIDTH), .NUM_LAYERS(NUM_LAYERS)) u_layer_sequencer (
    .clk(clk), .reset(reset), .render_start(render_start),
    .layer_regs(layer_regs), .draw(draw), .layer(layer), .render_x(render_x)
  );

  tile_fetch #(.IMAGE_WIDTH(IMAGE_WIDTH), .NUM_LAYERS(NUM_LAYERS)) u_tile_fetch (
    .clk(clk), .reset(reset), .draw(draw), .layer(layer), .render_x(render_x),
    .render_row(render_row), .render_half(render_half),
    .layer_regs(layer_regs), .scroll(scroll),
    .map_addr(map_addr), .map_data(map_data),
    .vram_addr(vram_addr), .vram_data(vram_data),
    .pal_addr(pal_addr), .pal_data(pal_data),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  line_buffer #(.IMAGE_WIDTH(IMAGE_WIDTH)) u_line_buffer (
    .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_addr(rd_addr), .clear(clear), .rd_data(rd_data)
  );

  scanout #(.IMAGE_WIDTH(IMAGE_WIDTH)) u_scanout (
    .clk(clk), .reset(reset), .scan_pos(scan_pos),
    .rd_addr(rd_addr), .clear(clear), .rd_data(rd_data),
    .rgb_out(rgb_out), .de(de)
  );

endmodule

`default_nettype wire

//--- tests/video_memories.sv
/* Behavioral tilemap, VRAM and palette memories for the renderer testbench */
`timescale 1ns/1ps
`default_nettype none

module video_memories (
  input  logic clk,
  input  logic [renderer_pkg::MAP_ADDR_WIDTH-1:0] map_addr,
  output logic [renderer_pkg::MAP_DATA_WIDTH-1:0] map_data,
  input  logic [renderer_pkg::VRAM_ADDR_WIDTH-1:0] vram_addr,
  output logic [renderer_pkg::VRAM_DATA_WIDTH-1:0] vram_data,
  input  logic [renderer_pkg::PAL_ADDR_WIDTH-1:0] pal_addr,
  output logic [renderer_pkg::PAL_DATA_WIDTH-1:0] pal_data
);
  import renderer_pkg::*;

  // Contents are loaded by the testbench through hierarchical writes
  logic [MAP_DATA_WIDTH-1:0] map_mem [2**MAP_ADDR_WIDTH];
  logic [VRAM_DATA_WIDTH-1:0] vram_mem [2**VRAM_ADDR_WIDTH];
  logic [PAL_DATA_WIDTH-1:0] pal_mem [2**PAL_ADDR_WIDTH];

  // Tilemap address is combinational in the renderer, sampled here
  always_ff @(posedge clk) begin
    map_data <= map_mem[map_addr];
  end

  // VRAM address register sits in the renderer, read follows it directly
  assign vram_data = vram_mem[vram_addr];

  // Palette address is combinational in the renderer, sampled here
  always_ff @(posedge clk) begin
    pal_data <= pal_mem[pal_addr];
  end

endmodule

`default_nettype wire

//--- tests/renderer_tb.sv
/* Renderer testbench with clock, reset, DUT, memory models, pixel reference model,
   directed tests and cycle timeout */
`timescale 1ns/1ps
`default_nettype none

module renderer_tb;
  import renderer_pkg::*;

  // Small raster with syncs after the visible area
  localparam int IMAGE_WIDTH = 32;
  localparam int IMAGE_HEIGHT = 16;
  localparam int H_TOTAL = 96;
  localparam int H_SYNC_START = 72;
  localparam int H_SYNC_END = 84;
  localparam int V_TOTAL = 40;
  localparam int V_SYNC_START = 34;
  localparam int V_SYNC_END = 36;
  localparam int NUM_LAYERS = 2;
  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 5;
  localparam int LINE_PIXELS = 2 * IMAGE_WIDTH;
  localparam int FRAME_PIXELS = 4 * IMAGE_WIDTH * IMAGE_HEIGHT;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  // Eight captured frames over all tests and up to two skipped before each
  localparam int CAPTURED_FRAMES = 8;
  localparam int TIMEOUT_CYCLES = FRAME_CYCLES * (3 * CAPTURED_FRAMES + 2);
  localparam logic [15:0] NOP_WORD = 16'hbeef;

  logic clk;
  logic reset;
  tile_layer_regs_t [NUM_LAYERS-1:0] layer_regs;
  scroll_regs_t scroll;
  logic [MAP_ADDR_WIDTH-1:0] map_addr;
  logic [MAP_DATA_WIDTH-1:0] map_data;
  logic [VRAM_ADDR_WIDTH-1:0] vram_addr;
  logic [VRAM_DATA_WIDTH-1:0] vram_data;
  logic [PAL_ADDR_WIDTH-1:0] pal_addr;
  logic [PAL_DATA_WIDTH-1:0] pal_data;
  logic h_sync;
  logic v_sync;
  logic [RGB_WIDTH-1:0] rgb_out;
  logic de;
  logic [31:0] rng_state;
  int cycle_count = 0;
  logic [RGB_WIDTH-1:0] captured [2][FRAME_PIXELS];

  renderer #(
    .IMAGE_WIDTH(IMAGE_WIDTH), .IMAGE_HEIGHT(IMAGE_HEIGHT),
    .H_TOTAL(H_TOTAL), .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
    .V_TOTAL(V_TOTAL), .V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END),
    .NUM_LAYERS(NUM_LAYERS)
  ) u_renderer (
    .clk(clk), .reset(reset), .layer_regs(layer_regs), .scroll(scroll),
    .map_addr(map_addr), .map_data(map_data),
    .vram_addr(vram_addr), .vram_data(vram_data),
    .pal_addr(pal_addr), .pal_data(pal_data),
    .h_sync(h_sync), .v_sync(v_sync), .rgb_out(rgb_out), .de(de)
  );

  video_memories u_memories (
    .clk(clk), .map_addr(map_addr), .map_data(map_data),
    .vram_addr(vram_addr), .vram_data(vram_data),
    .pal_addr(pal_addr), .pal_data(pal_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
    $display("tests failed");
    $fatal(1, "stopped at the first failed check");
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("tests failed");
    $fatal(1, "stopped at the first failed check");
  endtask

  // LCG with the usual 32-bit constants
  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  // Random map, VRAM and palette with texels limited by the mask
  task automatic fill_memories(input logic [7:0] texel_mask);
    logic [31:0] word;
    for (int a = 0; a < 2**MAP_ADDR_WIDTH; a++) begin
      word = next_random();
      u_memories.map_mem[a] = word[31:16];
    end
    for (int a = 0; a < 2**VRAM_ADDR_WIDTH; a++) begin
      word = next_random();
      u_memories.vram_mem[a] = word[31:16] & {texel_mask, texel_mask};
    end
    for (int a = 0; a < 2**PAL_ADDR_WIDTH; a++) begin
      word = next_random();
      u_memories.pal_mem[a] = word[31:8];
    end
  endtask

  // Color of one layer at an image position and whether the layer draws it
  function automatic logic layer_pixel(input int l, input int row, input int x,
                                       output logic [PAL_DATA_WIDTH-1:0] color);
    tile_layer_regs_t regs;
    logic [15:0] wx;
    logic [15:0] wy;
    logic [15:0] mword;
    logic [15:0] tile;
    logic [15:0] vaddr;
    logic [15:0] vword;
    logic [3:0] tx;
    logic [3:0] ty;
    logic [3:0] swap;
    logic [7:0] texel;
    regs = layer_regs[l];
    color = '0;
    // World position wraps at 32 tiles of 16 texels
    wx = 16'(x) + scroll.scroll_x - regs.offset_x;
    wy = 16'(row) + scroll.scroll_y - regs.offset_y;
    mword = u_memories.map_mem[{l[0], wy[8:4], wx[8:4]}];
    tile = regs.flip_enable ? {3'b000, mword[12:0]} : mword;
    tx = wx[3:0];
    ty = wy[3:0];
    if (regs.flip_enable && mword[13]) begin
      swap = tx;
      tx = ty;
      ty = swap;
    end
    if (regs.flip_enable && mword[15]) begin
      tx = 4'd15 - tx;
    end
    if (regs.flip_enable && mword[14]) begin
      ty = 4'd15 - ty;
    end
    // Eight words per tile row and 128 words per tile
    vaddr = tile * 16'd128 + 16'(ty) * 16'd8 + 16'(tx / 2) + regs.data_offset / 16'd2;
    vword = u_memories.vram_mem[vaddr];
    texel = tx[0] ? vword[15:8] : vword[7:0];
    if (regs.nop_enable && mword == regs.nop_value) begin
      return 1'b0;
    end
    if (regs.transp_enable && {8'h00, texel} == regs.color_key) begin
      return 1'b0;
    end
    color = u_memories.pal_mem[{regs.palette, texel}];
    return 1'b1;
  endfunction

  // Later layers cover earlier ones and empty pixels are black
  function automatic logic [RGB_WIDTH-1:0] expected_rgb(input int row, input int x);
    logic [PAL_DATA_WIDTH-1:0] color;
    logic [PAL_DATA_WIDTH-1:0] layer_color;
    color = '0;
    for (int l = 0; l < NUM_LAYERS; l++) begin
      if (layer_regs[l].enabled && layer_pixel(l, row, x, layer_color)) begin
        color = layer_color;
      end
    end
    return {color[23:18], color[15:10], color[7:2]};
  endfunction

  task automatic clear_registers();
    @(posedge clk);
    #1;
    layer_regs = '0;
    scroll = '0;
  endtask

  // Settle new registers through a full frame
  task automatic skip_two_frames();
    repeat (2) @(negedge v_sync);
  endtask

  // Store every de cycle of one frame and check line lengths and blanking
  task automatic capture_frame(input int slot);
    int count;
    int run;
    count = 0;
    run = 0;
    while (count < FRAME_PIXELS) begin
      @(negedge clk);
      if (de) begin
        captured[slot][count] = rgb_out;
        count++;
        run++;
      end else begin
        assert (rgb_out == '0) else report_mismatch("rgb_out in blanking", rgb_out, 0);
        if (run != 0) begin
          assert (run == LINE_PIXELS) else report_mismatch("de cycles per line", run,
                                                            LINE_PIXELS);
          run = 0;
        end
      end
    end
    @(negedge clk);
    assert (!de) else report_failure("de stayed high past the last line of the frame");
  endtask

  task automatic compare_with_model(input int slot);
    int row;
    int x;
    logic [RGB_WIDTH-1:0] expected;
    for (int k = 0; k < FRAME_PIXELS; k++) begin
      row = k / LINE_PIXELS / 2;
      x = (k % LINE_PIXELS) / 2;
      expected = expected_rgb(row, x);
      assert (captured[slot][k] == expected)
      else report_mismatch($sformatf("rgb_out at row %0d x %0d", row, x),
                           captured[slot][k], expected);
    end
  endtask

  task automatic check_one_frame();
    skip_two_frames();
    capture_frame(0);
    compare_with_model(0);
  endtask

  // Outputs idle in and right after reset while syncs wait for their windows
  task automatic reset_defaults();
    int cycles;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      assert (de == 1'b0) else report_mismatch("de", de, 0);
      assert (rgb_out == '0) else report_mismatch("rgb_out", rgb_out, 0);
      assert (h_sync == 1'b1) else report_mismatch("h_sync", h_sync, 1);
      assert (v_sync == 1'b1) else report_mismatch("v_sync", v_sync, 1);
    end
    @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    assert (de == 1'b0) else report_mismatch("de", de, 0);
    assert (rgb_out == '0) else report_mismatch("rgb_out", rgb_out, 0);
    cycles = 0;
    while (h_sync) begin
      assert (v_sync == 1'b1) else report_mismatch("v_sync", v_sync, 1);
      @(negedge clk);
      cycles++;
    end
    assert (cycles >= H_SYNC_START) else report_mismatch("cycles before h_sync", cycles,
                                                         H_SYNC_START);
  endtask

  task automatic plain_layer_frame();
    clear_registers();
    layer_regs[0].enabled = 1'b1;
    check_one_frame();
  endtask

  // Scroll and offsets push the window across both world edges
  task automatic scrolled_layer_frame();
    clear_registers();
    layer_regs[0].enabled = 1'b1;
    layer_regs[0].palette = 2'd3;
    layer_regs[0].data_offset = 16'h0246;
    layer_regs[0].offset_x = 16'd7;
    layer_regs[0].offset_y = 16'd20;
    scroll.scroll_x = 16'd500;
    scroll.scroll_y = 16'd5;
    check_one_frame();
  endtask

  // Same map words with and without flip decoding
  task automatic flipped_tiles();
    clear_registers();
    // The six visible tiles carry each flip bit alone and in pairs
    for (int r = 0; r < 2; r++) begin
      for (int c = 0; c < 3; c++) begin
        u_memories.map_mem[r * 32 + c][15:13] = 3'(r * 3 + c + 1);
      end
    end
    layer_regs[0].enabled = 1'b1;
    layer_regs[0].flip_enable = 1'b1;
    layer_regs[0].palette = 2'd1;
    scroll.scroll_x = 16'd3;
    scroll.scroll_y = 16'd9;
    check_one_frame();
    clear_registers();
    layer_regs[0].enabled = 1'b1;
    layer_regs[0].palette = 2'd1;
    scroll.scroll_x = 16'd3;
    scroll.scroll_y = 16'd9;
    check_one_frame();
  endtask

  task automatic set_two_layers();
    clear_registers();
    layer_regs[0].enabled = 1'b1;
    layer_regs[0].transp_enable = 1'b1;
    layer_regs[0].color_key = 16'h0003;
    layer_regs[0].palette = 2'd1;
    layer_regs[1].enabled = 1'b1;
    layer_regs[1].nop_enable = 1'b1;
    layer_regs[1].nop_value = NOP_WORD;
    layer_regs[1].transp_enable = 1'b1;
    layer_regs[1].color_key = 16'h0005;
    layer_regs[1].palette = 2'd2;
    layer_regs[1].offset_x = 16'd3;
  endtask

  // Layer 1 with nop tiles and keyed texels over a keyed layer 0
  task automatic layer_priority();
    int under_count;
    int empty_count;
    logic [PAL_DATA_WIDTH-1:0] color;
    logic drawn0;
    logic drawn1;
    set_two_layers();
    // Sixteen texel values make key hits common
    fill_memories(8'h0f);
    for (int a = 0; a < 2**(MAP_ADDR_WIDTH-1); a += 3) begin
      u_memories.map_mem[2**(MAP_ADDR_WIDTH-1) + a] = NOP_WORD;
    end
    check_one_frame();
    under_count = 0;
    empty_count = 0;
    for (int row = 0; row < IMAGE_HEIGHT; row++) begin
      for (int x = 0; x < IMAGE_WIDTH; x++) begin
        drawn0 = layer_pixel(0, row, x, color);
        drawn1 = layer_pixel(1, row, x, color);
        under_count += (!drawn1 && drawn0) ? 1 : 0;
        empty_count += (!drawn1 && !drawn0) ? 1 : 0;
      end
    end
    assert (under_count > 0 && empty_count > 0)
    else report_failure("frame has no layer 0 pixels under layer 1 or no empty pixels");
    // Layer 1 alone
    clear_registers();
    set_two_layers();
    layer_regs[0].enabled = 1'b0;
    check_one_frame();
  endtask

  // Back to back frames match when cleared entries leave nothing behind
  task automatic repeated_frames();
    set_two_layers();
    skip_two_frames();
    capture_frame(0);
    capture_frame(1);
    compare_with_model(0);
    for (int k = 0; k < FRAME_PIXELS; k++) begin
      assert (captured[1][k] == captured[0][k])
      else report_mismatch($sformatf("rgb_out second frame pixel %0d", k),
                           captured[1][k], captured[0][k]);
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    layer_regs = '0;
    scroll = '0;
    rng_state = 32'd21;
    fill_memories(8'hff);
    reset_defaults();
    plain_layer_frame();
    scrolled_layer_frame();
    flipped_tiles();
    layer_priority();
    repeated_frames();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
source/renderer_pkg.sv
source/scan_timing.sv
source/layer_sequencer.sv
source/tile_fetch.sv
source/line_buffer.sv
source/scanout.sv
source/renderer.sv
tests/video_memories.sv
tests/renderer_tb.sv

//--- Bender.yml
package:
  name: renderer

sources:
  - files:
      - source/renderer_pkg.sv
      - source/scan_timing.sv
      - source/layer_sequencer.sv
      - source/tile_fetch.sv
      - source/line_buffer.sv
      - source/scanout.sv
      - source/renderer.sv
  - target: test
    files:
      - tests/video_memories.sv
      - tests/renderer_tb.sv
